// File: logic/rv_pkg.sv
package rv_pkg;

  localparam int XLEN      = 32;
  localparam int MEM_WORDS = 256;  // both memories

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [7:0]      mem_index_t;

  localparam word_t RESET_PC = 32'h0000_3000;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;  // also addi
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_WORD    = 3'b010;  // lw and sw
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BLTU    = 3'b110;

  typedef enum logic [3:0] {
    op_nop, op_hold, op_add, op_sub, op_addi, op_slli,
    op_lw, op_sw, op_auipc, op_jal, op_beq, op_bltu
  } op_e;

  typedef struct packed {
    op_e       op;
    reg_addr_t rd;
    word_t     imm;
    logic      rf_we;
  } decode_t;

  typedef struct packed {
    word_t      y;           // alu or link value
    mem_index_t mem_index;
    word_t      store_data;
    word_t      next_pc;
  } exec_t;

  typedef struct packed {
    logic       en;
    mem_index_t addr;        // low 5 bits pick a register
    word_t      wdata;
    logic       we_imem;
    logic       we_dmem;
  } dbg_req_t;

  typedef struct packed {
    word_t rf_data;
    word_t imem_data;
    word_t dmem_data;
  } dbg_rsp_t;

endpackage

// File: logic/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
  input  logic             clk_cpu,
  input  logic             rstn,
  input  rv_pkg::word_t    next_pc,
  input  rv_pkg::dbg_req_t dbg,
  output rv_pkg::word_t    pc,
  output rv_pkg::word_t    instr,
  output rv_pkg::word_t    imem_data
);

  rv_pkg::word_t imem [rv_pkg::MEM_WORDS];

  rv_pkg::mem_index_t fetch_index;

  assign fetch_index = pc[9:2];  // word index, upper pc bits ignored

  // next_pc already equals pc while the core is held
  always_ff @(posedge clk_cpu or negedge rstn) begin
    if (!rstn) begin
      pc <= rv_pkg::RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (dbg.we_imem) begin
      imem[dbg.addr] <= dbg.wdata;  // program load
    end
  end

  assign instr     = imem[fetch_index];
  assign imem_data = imem[dbg.addr];  // debug readback

  // jal and branch offsets only guarantee bit 0 clear
  pc_word_aligned: assert property (
    @(posedge clk_cpu) disable iff (!rstn)
    pc[1:0] == 2'b00
  );

endmodule

// File: logic/instr_decode.sv
`timescale 1ns/1ns

module instr_decode (
  input  rv_pkg::word_t     instr,
  input  logic              dbg_en,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::decode_t   dec
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_u;
  rv_pkg::word_t imm_j;
  rv_pkg::word_t shamt;
  rv_pkg::op_e   op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign shamt = {27'd0, instr[24:20]};

  always_comb begin
    op = rv_pkg::op_nop;  // anything unknown retires as nop
    case (opcode)
      rv_pkg::OPC_OP: begin
        if (funct3 == rv_pkg::F3_ADD_SUB) begin
          op = instr[30] ? rv_pkg::op_sub : rv_pkg::op_add;
        end
      end
      rv_pkg::OPC_OP_IMM: begin
        if (funct3 == rv_pkg::F3_ADD_SUB) begin
          op = rv_pkg::op_addi;
        end else if (funct3 == rv_pkg::F3_SLL) begin
          op = rv_pkg::op_slli;
        end
      end
      rv_pkg::OPC_LOAD: begin
        if (funct3 == rv_pkg::F3_WORD) begin
          op = rv_pkg::op_lw;
        end
      end
      rv_pkg::OPC_STORE: begin
        if (funct3 == rv_pkg::F3_WORD) begin
          op = rv_pkg::op_sw;
        end
      end
      rv_pkg::OPC_AUIPC: op = rv_pkg::op_auipc;
      rv_pkg::OPC_JAL:   op = rv_pkg::op_jal;
      rv_pkg::OPC_BRANCH: begin
        if (funct3 == rv_pkg::F3_BEQ) begin
          op = rv_pkg::op_beq;
        end else if (funct3 == rv_pkg::F3_BLTU) begin
          op = rv_pkg::op_bltu;
        end
      end
      default: op = rv_pkg::op_nop;
    endcase
  end

  always_comb begin
    dec.op    = op;
    dec.rd    = instr[11:7];
    dec.rf_we = op inside {rv_pkg::op_add, rv_pkg::op_sub, rv_pkg::op_addi,
                           rv_pkg::op_slli, rv_pkg::op_lw, rv_pkg::op_auipc,
                           rv_pkg::op_jal};
    case (op)
      rv_pkg::op_addi, rv_pkg::op_lw:   dec.imm = imm_i;
      rv_pkg::op_slli:                  dec.imm = shamt;
      rv_pkg::op_sw:                    dec.imm = imm_s;
      rv_pkg::op_auipc:                 dec.imm = imm_u;
      rv_pkg::op_jal:                   dec.imm = imm_j;
      rv_pkg::op_beq, rv_pkg::op_bltu:  dec.imm = imm_b;
      default:                          dec.imm = '0;
    endcase
    if (dbg_en) begin  // debug owns the machine
      dec.op    = rv_pkg::op_hold;
      dec.rf_we = 1'b0;
      dec.imm   = '0;
    end
  end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic              clk_cpu,
  input  logic              rstn,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  rv_pkg::reg_addr_t dbg_addr,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     wd,
  output rv_pkg::word_t     rd1,
  output rv_pkg::word_t     rd2,
  output rv_pkg::word_t     dbg_data
);

  rv_pkg::word_t regs [32];

  always_ff @(posedge clk_cpu or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin  // x0 stays zero
      regs[rd] <= wd;
    end
  end

  assign rd1      = regs[rs1];
  assign rd2      = regs[rs2];
  assign dbg_data = regs[dbg_addr];

  x0_reads_zero: assert property (
    @(posedge clk_cpu) disable iff (!rstn)
    rs1 == 5'd0 |-> rd1 == '0
  );

endmodule

// File: logic/alu_execute.sv
`timescale 1ns/1ns

module alu_execute (
  input  rv_pkg::word_t   pc,
  input  rv_pkg::decode_t dec,
  input  rv_pkg::word_t   rd1,
  input  rv_pkg::word_t   rd2,
  output rv_pkg::exec_t   ex
);

  rv_pkg::word_t sum_imm;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t pc_imm;
  logic          taken;

  assign sum_imm  = rd1 + dec.imm;  // addi result and memory address
  assign pc_plus4 = pc + 32'd4;
  assign pc_imm   = pc + dec.imm;

  always_comb begin
    ex.y  = '0;
    taken = 1'b0;
    case (dec.op)
      rv_pkg::op_add:   ex.y = rd1 + rd2;
      rv_pkg::op_sub:   ex.y = rd1 - rd2;
      rv_pkg::op_addi:  ex.y = sum_imm;
      rv_pkg::op_slli:  ex.y = rd1 << dec.imm[4:0];
      rv_pkg::op_auipc: ex.y = pc_imm;
      rv_pkg::op_jal: begin
        ex.y  = pc_plus4;  // link
        taken = 1'b1;
      end
      rv_pkg::op_beq:   taken = (rd1 == rd2);
      rv_pkg::op_bltu:  taken = (rd1 < rd2);  // word_t is unsigned
      default:          ex.y = '0;
    endcase

    if (dec.op == rv_pkg::op_hold) begin
      ex.next_pc = pc;
    end else begin
      ex.next_pc = taken ? pc_imm : pc_plus4;
    end
    ex.mem_index  = sum_imm[9:2];
    ex.store_data = rd2;
  end

endmodule

// File: logic/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit (
  input  logic             clk_cpu,
  input  rv_pkg::decode_t  dec,
  input  rv_pkg::exec_t    ex,
  input  rv_pkg::dbg_req_t dbg,
  output rv_pkg::word_t    wb_data,
  output rv_pkg::word_t    dmem_data
);

  rv_pkg::word_t dmem [rv_pkg::MEM_WORDS];

  logic is_store;
  logic is_load;

  assign is_store = (dec.op == rv_pkg::op_sw);
  assign is_load  = (dec.op == rv_pkg::op_lw);

  // a debug write and a core store never meet, the op is held while en is up
  always_ff @(posedge clk_cpu) begin
    if (dbg.we_dmem) begin
      dmem[dbg.addr] <= dbg.wdata;
    end else if (is_store) begin
      dmem[ex.mem_index] <= ex.store_data;
    end
  end

  assign wb_data   = is_load ? dmem[ex.mem_index] : ex.y;  // write-back select
  assign dmem_data = dmem[dbg.addr];

  // strobes only mean something with the core stopped
  dmem_write_needs_en: assert property (
    @(posedge clk_cpu)
    dbg.we_dmem |-> dbg.en
  );

  imem_write_needs_en: assert property (
    @(posedge clk_cpu)
    dbg.we_imem |-> dbg.en
  );

endmodule

// File: logic/single_cycle_cpu.sv
`timescale 1ns/1ns

module single_cycle_cpu (
  input  logic             clk_cpu,
  input  logic             rstn,
  input  rv_pkg::dbg_req_t dbg,
  output rv_pkg::dbg_rsp_t rsp,
  output rv_pkg::word_t    pc,
  output rv_pkg::word_t    instr
);

  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::decode_t   dec;
  rv_pkg::exec_t     ex;
  rv_pkg::word_t     rd1;
  rv_pkg::word_t     rd2;
  rv_pkg::word_t     wb_data;
  rv_pkg::word_t     rf_dbg_data;
  rv_pkg::word_t     imem_dbg_data;
  rv_pkg::word_t     dmem_dbg_data;

  assign rsp = '{rf_data: rf_dbg_data, imem_data: imem_dbg_data, dmem_data: dmem_dbg_data};

  fetch_unit u_fetch (
    .clk_cpu   (clk_cpu),
    .rstn      (rstn),
    .next_pc   (ex.next_pc),
    .dbg       (dbg),
    .pc        (pc),
    .instr     (instr),
    .imem_data (imem_dbg_data)
  );

  instr_decode u_decode (
    .instr  (instr),
    .dbg_en (dbg.en),
    .rs1    (rs1),
    .rs2    (rs2),
    .dec    (dec)
  );

  reg_file u_rf (
    .clk_cpu  (clk_cpu),
    .rstn     (rstn),
    .rs1      (rs1),
    .rs2      (rs2),
    .dbg_addr (dbg.addr[4:0]),
    .we       (dec.rf_we),
    .rd       (dec.rd),
    .wd       (wb_data),
    .rd1      (rd1),
    .rd2      (rd2),
    .dbg_data (rf_dbg_data)
  );

  alu_execute u_exec (
    .pc  (pc),
    .dec (dec),
    .rd1 (rd1),
    .rd2 (rd2),
    .ex  (ex)
  );

  load_store_unit u_lsu (
    .clk_cpu   (clk_cpu),
    .dec       (dec),
    .ex        (ex),
    .dbg       (dbg),
    .wb_data   (wb_data),
    .dmem_data (dmem_dbg_data)
  );

endmodule

// File: bench/tb_single_cycle_cpu.sv
`timescale 1ns/1ns

module tb_single_cycle_cpu;

  logic             clk_cpu;
  logic             rstn;
  rv_pkg::dbg_req_t dbg;
  rv_pkg::dbg_rsp_t rsp;
  rv_pkg::word_t    pc;
  rv_pkg::word_t    instr;

  rv_pkg::word_t mx [32];  // model registers
  rv_pkg::word_t mimem [256];
  rv_pkg::word_t mdm [256];
  rv_pkg::word_t mpc;

  single_cycle_cpu dut0 (.*);

  initial begin
    clk_cpu = 1'b0;
    forever #50 clk_cpu = ~clk_cpu;
  end

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(input string name, input rv_pkg::word_t expected,
                       input rv_pkg::word_t actual);
    if (actual !== expected) begin
      abort($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  function automatic rv_pkg::word_t r_type(input int sub, rd, rs1, rs2);
    return {1'b0, sub[0], 5'd0, rs2[4:0], rs1[4:0], 3'd0, rd[4:0], 7'h33};
  endfunction

  function automatic rv_pkg::word_t i_type(input int opc, f3, rd, rs1, imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic rv_pkg::word_t s_type(input int imm, rs1, rs2);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'd2, imm[4:0], 7'h23};
  endfunction

  function automatic rv_pkg::word_t b_type(input int f3, rs1, rs2, imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic rv_pkg::word_t j_type(input int rd, imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  task automatic drive(input int en, addr, wdata, we_imem, we_dmem);
    @(posedge clk_cpu);
    dbg <= '{en[0], addr[7:0], wdata, we_imem[0], we_dmem[0]};
  endtask

  task automatic peek(input int idx, output rv_pkg::dbg_rsp_t r);
    drive(1, idx, 0, 0, 0);
    @(negedge clk_cpu);  // debug reads are combinational
    r = rsp;
  endtask

  task automatic mem_write(input int to_imem, input int idx, input rv_pkg::word_t data);
    drive(1, idx, data, to_imem, 1 - to_imem);
    drive(1, idx, 0, 0, 0);  // write lands on this edge
    if (to_imem != 0) begin
      mimem[idx[7:0]] = data;
    end else begin
      mdm[idx[7:0]] = data;
    end
  endtask

  task automatic load_prog(input rv_pkg::word_t p[$]);
    foreach (p[i]) begin
      mem_write(1, int'(mpc[9:2]) + i, p[i]);
    end
  endtask

  task automatic run(input int n);
    int cnt;
    drive(0, 0, 0, 0, 0);  // core retires from the next edge on
    cnt = 0;
    while (cnt < n && cnt < 64) begin
      @(posedge clk_cpu);
      cnt++;
    end
    dbg <= '{1'b1, 8'd0, 32'd0, 1'b0, 1'b0};
    if (cnt != n) begin
      abort("run loop reached its timeout before the requested instruction count");
    end
  endtask

  // one instruction of the reference model
  task automatic model_step();
    rv_pkg::word_t ins;
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t addr;
    rv_pkg::word_t res;
    rv_pkg::word_t nxt;
    logic          wr;
    ins  = mimem[mpc[9:2]];
    a    = mx[ins[19:15]];
    b    = mx[ins[24:20]];
    addr = a + ((ins[6:0] == 7'h23) ? {{20{ins[31]}}, ins[31:25], ins[11:7]}
                                    : {{20{ins[31]}}, ins[31:20]});  // also the addi sum
    res  = '0;
    nxt  = mpc + 4;
    wr   = 1'b1;
    case (ins[6:0])
      7'h33: res = ins[30] ? a - b : a + b;
      7'h13: res = (ins[14:12] == 3'd1) ? a << ins[24:20] : addr;
      7'h03: res = mdm[addr[9:2]];
      7'h17: res = mpc + {ins[31:12], 12'h000};
      7'h6f: begin
        res = mpc + 4;  // link
        nxt = mpc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'h23: begin
        mdm[addr[9:2]] = b;
        wr = 1'b0;
      end
      7'h63: begin
        if ((ins[14:12] == 3'd0) ? (a == b) : (a < b)) begin
          nxt = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        wr = 1'b0;
      end
      default: wr = 1'b0;  // undefined opcode, pc plus 4 only
    endcase
    if (wr && ins[11:7] != 5'd0) begin
      mx[ins[11:7]] = res;
    end
    mpc = nxt;
  endtask

  task automatic compare_state(input string name);
    rv_pkg::dbg_rsp_t r;
    for (int i = 0; i < 32; i++) begin
      peek(i, r);
      check($sformatf("%s x%0d", name, i), mx[i], r.rf_data);
    end
    check({name, " pc"}, mpc, pc);
    check({name, " instr"}, mimem[mpc[9:2]], instr);  // word fetched at the held pc
  endtask

  task automatic advance(input int n, input string name);
    for (int i = 0; i < n; i++) begin
      model_step();
    end
    run(n);
    compare_state(name);
  endtask

  task automatic debug_access();
    rv_pkg::dbg_rsp_t r;
    rv_pkg::word_t    iw;
    rv_pkg::word_t    dw;
    iw = $urandom;
    dw = $urandom;
    mem_write(1, 200, iw);
    mem_write(0, 77, dw);
    peek(200, r);
    check("debug imem readback", iw, r.imem_data);
    peek(77, r);
    check("debug dmem readback", dw, r.dmem_data);
    check("debug pc hold", mpc, pc);
  endtask

  task automatic arithmetic();
    rv_pkg::word_t p[$];
    p = {i_type('h13, 0, 1, 0, $urandom), i_type('h13, 0, 2, 0, $urandom),
         r_type(0, 3, 1, 2), r_type(1, 4, 1, 2), i_type('h13, 1, 5, 1, 7),
         {20'h12345, 5'd6, 7'h17}, i_type('h13, 0, 0, 1, 5)};  // last one targets x0
    load_prog(p);
    advance(p.size(), "arithmetic");
  endtask

  task automatic load_store();
    rv_pkg::word_t    p[$];
    rv_pkg::word_t    addr;
    rv_pkg::dbg_rsp_t r;
    p = {i_type('h13, 0, 7, 0, 'h40), s_type(12, 7, 3), i_type('h03, 2, 8, 7, 12)};
    load_prog(p);
    advance(p.size(), "load store");
    addr = mx[7] + 12;
    peek(int'(addr[9:2]), r);
    check("store readback", mx[3], r.dmem_data);
  endtask

  task automatic control_flow();
    rv_pkg::word_t p[$];
    p = {i_type('h13, 0, 9, 0, -1), i_type('h13, 0, 10, 0, 1),
         b_type(0, 10, 10, 8), i_type('h13, 0, 11, 0, 99),
         b_type(0, 9, 10, 8), b_type(6, 10, 9, 8),  // 1 below all ones unsigned
         i_type('h13, 0, 12, 0, 5), j_type(13, 8), i_type('h13, 0, 14, 0, 7)};
    load_prog(p);
    for (int s = 0; s < 6; s++) begin
      advance(1, $sformatf("control step %0d", s));
    end
  endtask

  task automatic debug_hold();
    rv_pkg::word_t p[$];
    p = {32'h0000_007f, i_type('h13, 0, 15, 0, 33), i_type('h13, 0, 16, 15, 1),
         i_type('h13, 0, 17, 16, 1)};
    load_prog(p);
    advance(1, "undefined opcode");
    advance(1, "before hold");
    for (int i = 0; i < 5; i++) begin
      drive(1, 0, 0, 0, 0);  // en held high
    end
    compare_state("during hold");
    advance(2, "after hold");
  endtask

  initial begin
    void'($urandom(32'hb6f6));
    rstn = 1'b0;
    dbg  = '{1'b1, 8'd0, 32'd0, 1'b0, 1'b0};  // core stays parked until a run
    mpc  = 32'h0000_3000;
    foreach (mx[i]) begin
      mx[i] = '0;
    end
    repeat (4) @(posedge clk_cpu);
    rstn <= 1'b1;
    compare_state("reset");
    debug_access();
    arithmetic();
    load_store();
    control_flow();
    debug_hold();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: single_cycle_cpu.f
logic/rv_pkg.sv
logic/fetch_unit.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/alu_execute.sv
logic/load_store_unit.sv
logic/single_cycle_cpu.sv
bench/tb_single_cycle_cpu.sv

// File: Makefile
TOP = tb_single_cycle_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f single_cycle_cpu.f --top-module single_cycle_cpu

sim:
	verilator --binary --timing --assert -f single_cycle_cpu.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
